//--- src/obi_mem_params.svh
// -------------------------------------------------
// width macros for the OBI memory subsystem
// bus, RAM and interrupt sizes
// -------------------------------------------------

`ifndef OBI_MEM_PARAMS_SVH
`define OBI_MEM_PARAMS_SVH

// bus widths, shared by fetch and load/store buses
`define OBI_ADDR_W    32
`define OBI_DATA_W    32
`define OBI_BE_W      4
`define OBI_BYTE_W    8

// ram geometry, word address taken from byte address bits above the lsb
`define OBI_RAM_AW    10
`define OBI_RAM_WORDS (1 << `OBI_RAM_AW)
`define OBI_ADDR_LSB  2

// interrupt lines and id width
`define OBI_IRQ_W     32
`define OBI_IRQ_ID_W  5

`endif

//--- src/obi_mem_pkg.sv
// -------------------------------------------------
// shared types for the OBI memory subsystem
// bus word seen as a word or as byte lanes
// -------------------------------------------------

`include "obi_mem_params.svh"

package obi_mem_pkg;

    // -------------------------------------------------
    // bus word
    // -------------------------------------------------

    // byte lanes, lane 0 is the least significant byte
    typedef logic [`OBI_BE_W-1:0][`OBI_BYTE_W-1:0] obi_lanes_t;

    // one data word, decoded either whole or per lane
    // the byte view is used for write merging under byte enables
    typedef union packed {
        logic [`OBI_DATA_W-1:0] word;
        obi_lanes_t             bytes;
    } obi_word_u;

endpackage : obi_mem_pkg

//--- src/obi_mem_ctrl.sv
// -------------------------------------------------
// OBI memory control
// grants fetch and load/store buses, one ram access
// per cycle, tracks and steers the responses
// -------------------------------------------------

`timescale 1ns/1ns

`include "obi_mem_params.svh"

module obi_mem_ctrl
    import obi_mem_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      arst_n_i,

    // instruction fetch bus, read only
    input  logic                      instr_req_i,
    input  logic [`OBI_ADDR_W-1:0]    instr_addr_i,
    output logic                      instr_gnt_o,
    output logic                      instr_rvalid_o,
    output logic [`OBI_DATA_W-1:0]    instr_rdata_o,

    // load/store bus
    input  logic                      data_req_i,
    input  logic [`OBI_ADDR_W-1:0]    data_addr_i,
    input  logic                      data_we_i,
    input  logic [`OBI_BE_W-1:0]      data_be_i,
    input  logic [`OBI_DATA_W-1:0]    data_wdata_i,
    output logic                      data_gnt_o,
    output logic                      data_rvalid_o,
    output logic [`OBI_DATA_W-1:0]    data_rdata_o,

    // single ram port
    output logic                      ram_en_o,
    output logic                      ram_we_o,
    output logic [`OBI_RAM_AW-1:0]    ram_addr_o,
    output logic [`OBI_BE_W-1:0]      ram_be_o,
    output obi_word_u                 ram_wdata_o,
    input  obi_word_u                 ram_rdata_i
);

    // response owner for the access issued last cycle
    logic rsp_instr_q;
    logic rsp_data_q;
    // data response belongs to a write, so rdata is zero
    logic rsp_we_q;

    // handshakes in this cycle
    logic instr_hs;
    logic data_hs;

    // -------------------------------------------------
    // arbitration
    // -------------------------------------------------

    // load/store has fixed priority and is always granted
    assign data_gnt_o  = data_req_i;
    // fetch only gets the port when no load/store asks
    assign instr_gnt_o = instr_req_i & ~data_req_i;

    assign data_hs  = data_req_i & data_gnt_o;
    assign instr_hs = instr_req_i & instr_gnt_o;

    // -------------------------------------------------
    // ram access
    // -------------------------------------------------

    // one access per cycle, whichever bus was granted
    assign ram_en_o = data_hs | instr_hs;

    // fetches are reads with all lanes enabled
    always_comb begin
        if (data_hs) begin
            ram_we_o   = data_we_i;
            ram_addr_o = data_addr_i[`OBI_RAM_AW+`OBI_ADDR_LSB-1:`OBI_ADDR_LSB];
            ram_be_o   = data_be_i;
        end else begin
            ram_we_o   = 1'b0;
            ram_addr_o = instr_addr_i[`OBI_RAM_AW+`OBI_ADDR_LSB-1:`OBI_ADDR_LSB];
            ram_be_o   = '1;
        end
    end

    // write data only matters on a load/store write
    assign ram_wdata_o.word = data_wdata_i;

    // -------------------------------------------------
    // response tracking
    // -------------------------------------------------

    // response follows the handshake by exactly one cycle
    // and a new handshake may land in the same cycle
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_instr_q <= 1'b0;
            rsp_data_q  <= 1'b0;
            rsp_we_q    <= 1'b0;
        end else begin
            rsp_instr_q <= instr_hs;
            rsp_data_q  <= data_hs;
            rsp_we_q    <= data_hs & data_we_i;
        end
    end

    assign instr_rvalid_o = rsp_instr_q;
    assign data_rvalid_o  = rsp_data_q;

    // steer the registered ram word to the owning bus
    // the other bus sees zero
    assign instr_rdata_o = rsp_instr_q ? ram_rdata_i.word : '0;
    // write responses carry zero
    assign data_rdata_o  = (rsp_data_q && !rsp_we_q) ? ram_rdata_i.word : '0;

endmodule : obi_mem_ctrl

//--- src/obi_sram.sv
// -------------------------------------------------
// single ported word ram
// byte enable write merge, registered read
// -------------------------------------------------

`timescale 1ns/1ns

`include "obi_mem_params.svh"

module obi_sram
    import obi_mem_pkg::*;
(
    input  logic                   clk_i,
    // access strobe from the control module
    input  logic                   en_i,
    input  logic                   we_i,
    // word address
    input  logic [`OBI_RAM_AW-1:0] addr_i,
    input  logic [`OBI_BE_W-1:0]   be_i,
    input  obi_word_u              wdata_i,
    // read word, valid the cycle after an enabled read
    output obi_word_u              rdata_o
);

    // storage array
    logic [`OBI_DATA_W-1:0] mem [`OBI_RAM_WORDS];

    // current word at the address, viewed as lanes
    obi_word_u cur_word;
    // word after merging the enabled lanes
    obi_word_u merged;

    // -------------------------------------------------
    // byte lane merge
    // -------------------------------------------------

    assign cur_word.word = mem[addr_i];

    always_comb begin
        merged = cur_word;
        // take new data only where the lane is enabled
        for (int i = 0; i < `OBI_BE_W; i++) begin
            if (be_i[i]) begin
                merged.bytes[i] = wdata_i.bytes[i];
            end
        end
    end

    // -------------------------------------------------
    // array write and read register
    // -------------------------------------------------

    // write is visible to any access in the next cycle
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            mem[addr_i] <= merged.word;
        end
    end

    // read word is held until the next enabled read
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            rdata_o <= cur_word;
        end
    end

endmodule : obi_sram

//--- src/obi_irq_pend.sv
// -------------------------------------------------
// interrupt pending register
// rising edge set, acknowledge clear by id
// -------------------------------------------------

`timescale 1ns/1ns

`include "obi_mem_params.svh"

module obi_irq_pend (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    // raw interrupt sources from the environment
    input  logic [`OBI_IRQ_W-1:0]    irq_src_i,
    // acknowledge from the core, with the taken id
    input  logic                     irq_ack_i,
    input  logic [`OBI_IRQ_ID_W-1:0] irq_id_i,
    // pending lines to the core
    output logic [`OBI_IRQ_W-1:0]    irq_o
);

    // source levels seen in the previous cycle
    logic [`OBI_IRQ_W-1:0] src_q;
    // pending bits
    logic [`OBI_IRQ_W-1:0] pend_q;
    logic [`OBI_IRQ_W-1:0] pend_d;

    // edge and clear masks
    logic [`OBI_IRQ_W-1:0] rise;
    logic [`OBI_IRQ_W-1:0] clr;

    // -------------------------------------------------
    // edge detect and ack decode
    // -------------------------------------------------

    // low last cycle, high now
    assign rise = irq_src_i & ~src_q;

    // one hot clear for the acknowledged id
    always_comb begin
        clr = '0;
        if (irq_ack_i) begin
            clr[irq_id_i] = 1'b1;
        end
    end

    // set wins when set and clear hit the same bit
    assign pend_d = (pend_q & ~clr) | rise;

    // -------------------------------------------------
    // state
    // -------------------------------------------------

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            src_q  <= '0;
            pend_q <= '0;
        end else begin
            src_q  <= irq_src_i;
            pend_q <= pend_d;
        end
    end

    assign irq_o = pend_q;

endmodule : obi_irq_pend

//--- src/obi_mem_subsys.sv
// -------------------------------------------------
// OBI memory subsystem top level
// control, shared word ram and interrupt pending unit
// -------------------------------------------------

`timescale 1ns/1ns

`include "obi_mem_params.svh"

module obi_mem_subsys
    import obi_mem_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     arst_n_i,

    // instruction fetch bus
    input  logic                     instr_req_i,
    input  logic [`OBI_ADDR_W-1:0]   instr_addr_i,
    output logic                     instr_gnt_o,
    output logic                     instr_rvalid_o,
    output logic [`OBI_DATA_W-1:0]   instr_rdata_o,

    // load/store bus
    input  logic                     data_req_i,
    input  logic [`OBI_ADDR_W-1:0]   data_addr_i,
    input  logic                     data_we_i,
    input  logic [`OBI_BE_W-1:0]     data_be_i,
    input  logic [`OBI_DATA_W-1:0]   data_wdata_i,
    output logic                     data_gnt_o,
    output logic                     data_rvalid_o,
    output logic [`OBI_DATA_W-1:0]   data_rdata_o,

    // interrupts
    input  logic [`OBI_IRQ_W-1:0]    irq_src_i,
    output logic [`OBI_IRQ_W-1:0]    irq_o,
    input  logic                     irq_ack_i,
    input  logic [`OBI_IRQ_ID_W-1:0] irq_id_i
);

    // -------------------------------------------------
    // control to ram
    // -------------------------------------------------

    logic                   ram_en;
    logic                   ram_we;
    logic [`OBI_RAM_AW-1:0] ram_addr;
    logic [`OBI_BE_W-1:0]   ram_be;
    obi_word_u              ram_wdata;
    // registered read word back to control
    obi_word_u              ram_rdata;

    // arbiter and response steering
    obi_mem_ctrl u_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .ram_en_o       (ram_en),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_addr),
        .ram_be_o       (ram_be),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata)
    );

    // one port shared by fetch and load/store
    obi_sram u_ram (
        .clk_i   (clk_i),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .addr_i  (ram_addr),
        .be_i    (ram_be),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    // -------------------------------------------------
    // interrupts
    // -------------------------------------------------

    obi_irq_pend u_irq (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .irq_src_i (irq_src_i),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .irq_o     (irq_o)
    );

endmodule : obi_mem_subsys

//--- bench/obi_clk_gen.sv
// -------------------------------------------------
// testbench clock and reset
// 4 ns clock, reset held low for 16 cycles
// -------------------------------------------------

`timescale 1ns/1ns

module obi_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    localparam int HALF_PERIOD = 2;
    localparam int RST_CYCLES  = 16;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // release on a rising edge, flops still see reset on that edge
    initial begin
        arst_n_o <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        arst_n_o <= 1'b1;
    end

endmodule : obi_clk_gen

//--- bench/obi_mem_tb.sv
// -------------------------------------------------
// testbench for the OBI memory subsystem
// random fetch, load/store and interrupt stimulus
// ram, response and pending models and a watchdog
// -------------------------------------------------

`timescale 1ns/1ns

`include "obi_mem_params.svh"

module obi_mem_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RST_CYCLES = 16;
    // small address window so that the buses collide often
    localparam int NUM_WORDS  = 64;
    localparam int NUM_OPS    = 400;
    localparam int TOTAL_OPS  = NUM_WORDS + 2 * NUM_OPS;

    logic                     clk_i;
    logic                     arst_n_i;
    logic                     instr_req_i;
    logic [`OBI_ADDR_W-1:0]   instr_addr_i;
    logic                     instr_gnt_o;
    logic                     instr_rvalid_o;
    logic [`OBI_DATA_W-1:0]   instr_rdata_o;
    logic                     data_req_i;
    logic [`OBI_ADDR_W-1:0]   data_addr_i;
    logic                     data_we_i;
    logic [`OBI_BE_W-1:0]     data_be_i;
    logic [`OBI_DATA_W-1:0]   data_wdata_i;
    logic                     data_gnt_o;
    logic                     data_rvalid_o;
    logic [`OBI_DATA_W-1:0]   data_rdata_o;
    logic [`OBI_IRQ_W-1:0]    irq_src_i;
    logic [`OBI_IRQ_W-1:0]    irq_o;
    logic                     irq_ack_i;
    logic [`OBI_IRQ_ID_W-1:0] irq_id_i;

    // -------------------------------------------------
    // models and run state
    // -------------------------------------------------

    logic [`OBI_DATA_W-1:0] mem_model [NUM_WORDS];
    // expected response words filled at the handshake
    logic [`OBI_DATA_W-1:0] instr_exp_q [$];
    logic [`OBI_DATA_W-1:0] data_exp_q [$];
    logic [`OBI_IRQ_W-1:0]  pend_model;
    logic [`OBI_IRQ_W-1:0]  src_model;

    int unsigned mismatch_cnt = 0;
    bit          preload_done = 1'b0;
    bit          data_done    = 1'b0;
    bit          instr_done   = 1'b0;
    bit          run_done     = 1'b0;

    obi_clk_gen u_clk_gen (
        .clk_o    (clk_i),
        .arst_n_o (arst_n_i)
    );

    obi_mem_subsys u_dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_src_i      (irq_src_i),
        .irq_o          (irq_o),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
            mismatch_cnt++;
        end
    endtask

    // word index goes to bits 7:2 and random upper bits hit the ram alias
    function automatic logic [31:0] word_to_addr(input int unsigned word,
                                                 input logic [31:0] rnd);
        logic [31:0] addr;
        addr = {rnd[31:12], 4'b0000, word[5:0], 2'b00};
        return addr;
    endfunction

    // hold the request until granted and return on the transfer edge
    task automatic drive_data(input logic we, input logic [31:0] addr,
                              input logic [3:0] be, input logic [31:0] wdata);
        data_req_i   <= 1'b1;
        data_we_i    <= we;
        data_addr_i  <= addr;
        data_be_i    <= be;
        data_wdata_i <= wdata;
        @(negedge clk_i);
        while (!data_gnt_o) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    task automatic drive_fetch(input logic [31:0] addr);
        instr_req_i  <= 1'b1;
        instr_addr_i <= addr;
        @(negedge clk_i);
        while (!instr_gnt_o) @(negedge clk_i);
        @(posedge clk_i);
    endtask

    // -------------------------------------------------
    // stimulus
    // -------------------------------------------------

    initial begin : data_driver
        logic [31:0] rnd;
        logic [3:0]  be;
        int unsigned word;
        data_req_i   <= 1'b0;
        data_addr_i  <= '0;
        data_we_i    <= 1'b0;
        data_be_i    <= '0;
        data_wdata_i <= '0;
        wait (arst_n_i === 1'b1);
        @(posedge clk_i);
        // full word writes so no read ever sees an unwritten word
        for (word = 0; word < NUM_WORDS; word++) begin
            drive_data(1'b1, word_to_addr(word, $urandom), 4'hf, $urandom);
        end
        preload_done = 1'b1;
        repeat (NUM_OPS) begin
            rnd = $urandom;
            // idle cycles let the fetch bus in
            if (rnd % 3 == 0) begin
                data_req_i <= 1'b0;
                @(posedge clk_i);
            end
            word = $urandom % NUM_WORDS;
            be   = rnd[7:4];
            if (be == 4'h0) begin
                be = 4'h1;
            end
            drive_data(rnd[8], word_to_addr(word, $urandom), be, $urandom);
        end
        data_req_i <= 1'b0;
        data_done = 1'b1;
    end

    initial begin : fetch_driver
        logic [31:0] rnd;
        int unsigned word;
        instr_req_i  <= 1'b0;
        instr_addr_i <= '0;
        wait (preload_done);
        @(posedge clk_i);
        repeat (NUM_OPS) begin
            rnd = $urandom;
            if (rnd[1:0] == 2'b00) begin
                instr_req_i <= 1'b0;
                @(posedge clk_i);
            end
            word = $urandom % NUM_WORDS;
            drive_fetch(word_to_addr(word, $urandom));
        end
        instr_req_i <= 1'b0;
        instr_done = 1'b1;
    end

    initial begin : irq_driver
        logic [31:0] toggle;
        logic [31:0] src_next;
        logic [31:0] rising;
        logic [31:0] rnd;
        logic [4:0]  id;
        irq_src_i <= '0;
        irq_ack_i <= 1'b0;
        irq_id_i  <= '0;
        wait (arst_n_i === 1'b1);
        while (!run_done) begin
            @(posedge clk_i);
            // sparse toggles
            toggle   = $urandom & $urandom;
            src_next = irq_src_i ^ toggle;
            rising   = src_next & ~irq_src_i;
            rnd      = $urandom;
            id       = rnd[12:8];
            // now and then ack a line that rises in the same cycle
            if (rnd[2] && rising != '0) begin
                for (int i = `OBI_IRQ_W - 1; i >= 0; i--) begin
                    if (rising[i]) begin
                        id = i[4:0];
                    end
                end
            end
            irq_src_i <= src_next;
            irq_ack_i <= rnd[0];
            irq_id_i  <= id;
        end
    end

    // -------------------------------------------------
    // monitor sampling on the falling edge
    // -------------------------------------------------

    initial begin : monitor
        logic [31:0] exp;
        logic [31:0] merged;
        logic [31:0] rise;
        logic [31:0] clr;
        logic [5:0]  widx;
        pend_model = '0;
        src_model  = '0;
        repeat (RST_CYCLES / 2) @(negedge clk_i);
        check("reset_instr_rvalid", 32'h0, 32'(instr_rvalid_o));
        check("reset_data_rvalid", 32'h0, 32'(data_rvalid_o));
        check("reset_irq", 32'h0, irq_o);
        wait (arst_n_i === 1'b1);
        while (!run_done) begin
            @(negedge clk_i);
            // responses owed for last cycle's handshakes
            check("instr_rvalid", 32'(instr_exp_q.size() != 0), 32'(instr_rvalid_o));
            if (instr_exp_q.size() != 0) begin
                exp = instr_exp_q.pop_front();
                check("instr_rdata", exp, instr_rdata_o);
            end
            check("data_rvalid", 32'(data_exp_q.size() != 0), 32'(data_rvalid_o));
            if (data_exp_q.size() != 0) begin
                exp = data_exp_q.pop_front();
                check("data_rdata", exp, data_rdata_o);
            end
            // load/store has priority
            check("data_gnt", 32'(data_req_i), 32'(data_gnt_o));
            check("instr_gnt", 32'(instr_req_i & ~data_req_i), 32'(instr_gnt_o));
            check("irq_o", pend_model, irq_o);
            // handshakes in this cycle
            if (data_req_i) begin
                widx = data_addr_i[7:2];
                if (data_we_i) begin
                    merged = mem_model[widx];
                    for (int b = 0; b < `OBI_BE_W; b++) begin
                        if (data_be_i[b]) begin
                            merged[b*8 +: 8] = data_wdata_i[b*8 +: 8];
                        end
                    end
                    mem_model[widx] = merged;
                    data_exp_q.push_back('0);
                end else begin
                    data_exp_q.push_back(mem_model[widx]);
                end
            end else if (instr_req_i) begin
                instr_exp_q.push_back(mem_model[instr_addr_i[7:2]]);
            end
            // edge sets and ack clears with the set winning
            rise = irq_src_i & ~src_model;
            clr  = '0;
            if (irq_ack_i) begin
                clr[irq_id_i] = 1'b1;
            end
            pend_model = (pend_model & ~clr) | rise;
            src_model  = irq_src_i;
        end
    end

    // -------------------------------------------------
    // run control
    // -------------------------------------------------

    initial begin : main
        void'($urandom(86254));
        wait (data_done && instr_done);
        repeat (4) @(posedge clk_i);
        run_done = 1'b1;
        @(negedge clk_i);
        @(negedge clk_i);
        $display("errors: %0d mismatches, 0 timeouts", mismatch_cnt);
        if (mismatch_cnt == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // budget of 20 cycles per operation plus reset
    initial begin : watchdog
        #((RST_CYCLES + TOTAL_OPS * 20) * CLK_PERIOD);
        $display("error: the run timed out at %0t before all operations finished", $time);
        $display("errors: %0d mismatches, 1 timeouts", mismatch_cnt);
        $display("=== FAIL ===");
        $finish;
    end

endmodule : obi_mem_tb

//--- sim.f
+incdir+src
src/obi_mem_pkg.sv
src/obi_mem_ctrl.sv
src/obi_sram.sv
src/obi_irq_pend.sv
src/obi_mem_subsys.sv
bench/obi_clk_gen.sv
bench/obi_mem_tb.sv

//--- Makefile
# Verilator flow for the OBI memory subsystem testbench

TOOL  := verilator
TOP   := obi_mem_tb
FLIST := sim.f
FLAGS := --timing
BUILD := obj_dir
PASS  := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

# build, run, and decide the result from the printed output
sim:
	$(TOOL) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- "$(PASS)"

clean:
	rm -rf $(BUILD)
